// File: Bender.yml
package:
  name: scratch_mem

sources:
  # design, package first
  - files:
      - verilog/scratch_pkg.sv
      - verilog/sram_access_decode.sv
      - verilog/sram_sp_plain.sv
      - verilog/sram_load_align.sv
      - verilog/scratch_mem_top.sv

  # testbench
  - target: test
    files:
      - tests/scratch_mem_checker.sv
      - tests/scratch_mem_tb.sv

// File: compile.f
verilog/scratch_pkg.sv
verilog/sram_access_decode.sv
verilog/sram_sp_plain.sv
verilog/sram_load_align.sv
verilog/scratch_mem_top.sv
tests/scratch_mem_checker.sv
tests/scratch_mem_tb.sv

// File: tests/scratch_mem_checker.sv
`default_nettype none

module scratch_mem_checker (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,
   input  scratch_pkg::mem_req_t req,
   input  logic                  rsp_valid,
   input  scratch_pkg::mem_rsp_t rsp,
   input  logic                  end_of_test,   // stimulus done and drained
   output int                    value_errors,
   output int                    proto_errors
);
   timeunit 1ns;
   timeprecision 1ps;
   import scratch_pkg::*;

   logic [byte_w-1:0] model [2**addr_w];   // byte-wide shadow of the scratchpad, X until stored
   mem_rsp_t          exp_q [$];           // expected responses, oldest first
   int                due_q [$];           // cycle in which each one must show up
   int                cycle_n = 0;

   // bytes touched by an access of this size
   function automatic int size_bytes(input access_size_e s);
      case (s)
         size_byte: return 1;
         size_half: return 2;
         default:   return 4;
      endcase
   endfunction

   // response predicted from the current model contents
   function automatic mem_rsp_t expected_rsp(input mem_req_t r);
      mem_rsp_t          e;
      logic [data_w-1:0] v;
      int                n;
      n = size_bytes(r.size);
      e = '0;
      e.write = r.write;
      if ((r.addr % n) != 0) begin
         e.err = 1'b1;                            // misaligned, no data
      end else if (!r.write) begin
         v = '0;
         for (int i = 0; i < n; i++)
            v[8*i +: 8] = model[r.addr + i];      // little endian
         if (r.is_signed && n < 4 && v[8*n-1] === 1'b1) begin
            for (int i = n; i < 4; i++)
               v[8*i +: 8] = 8'hff;
         end
         e.rdata = v;
      end
      return e;
   endfunction

   // stores land in the model at request time
   task automatic apply_store(input mem_req_t r);
      int n;
      n = size_bytes(r.size);
      if (r.write && (r.addr % n) == 0) begin
         for (int i = 0; i < n; i++)
            model[r.addr + i] = r.wdata[8*i +: 8];
      end
   endtask

   task automatic compare_field(input string name, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   always @(posedge clk) begin
      mem_rsp_t head;
      int       due;
      cycle_n++;
      if (reset) begin
         if (rsp_valid === 1'b1) begin
            $display("rsp_valid was high during reset at %0t ns", $time);
            proto_errors++;
         end
      end else begin
         if (rsp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               $display("response pulse at %0t ns with no request outstanding", $time);
               proto_errors++;
            end else begin
               head = exp_q.pop_front();
               due  = due_q.pop_front();
               if (due != cycle_n) begin
                  $display("response at %0t ns came in cycle %0d, was due in cycle %0d",
                           $time, cycle_n, due);
                  proto_errors++;
               end
               compare_field("rsp.rdata", rsp.rdata, head.rdata);
               compare_field("rsp.err", rsp.err, head.err);
               compare_field("rsp.write", rsp.write, head.write);
            end
         end else if (rsp_valid !== 1'b0) begin
            $display("rsp_valid is unknown at %0t ns", $time);
            proto_errors++;
         end
         if (req_valid === 1'b1) begin
            exp_q.push_back(expected_rsp(req));   // read before own store
            due_q.push_back(cycle_n + 2);
            apply_store(req);
         end
         if (end_of_test && exp_q.size() != 0) begin
            $display("%0d expected responses never arrived before the end of the test",
                     exp_q.size());
            proto_errors += exp_q.size();
            exp_q.delete();
            due_q.delete();
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/scratch_mem_tb.sv
`default_nettype none

module scratch_mem_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import scratch_pkg::*;

   // requests per phase, the run limit follows from their sum
   localparam int n_fill      = 2 * mem_words;  // word store then load for every word
   localparam int n_lanes     = 4 * 12;         // 4 words, byte and half stores + readback
   localparam int n_extend    = 2 * 13;         // 2 patterns, 1 store + 12 loads
   localparam int n_misalign  = 11;
   localparam int n_random    = 400;
   localparam int n_requests  = n_fill + n_lanes + n_extend + n_misalign + n_random;
   localparam int cycle_limit = n_requests + 50;

   logic     clk = 1'b0;
   logic     reset;
   logic     req_valid;
   mem_req_t req;
   logic     rsp_valid;
   mem_rsp_t rsp;
   logic     end_of_test;
   int       value_errors;
   int       proto_errors;
   int       cycles = 0;
   integer   seed = 32'hfd27;

   always #4 clk = ~clk;                        // 8 ns period

   scratch_mem_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   scratch_mem_checker chk0 (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .end_of_test  (end_of_test),
      .value_errors (value_errors),
      .proto_errors (proto_errors)
   );

   // hard stop if the run overstays its budget
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout, run still going after %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic mem_req_t make_req(input int addr, input logic write,
                                         input access_size_e size, input logic is_signed,
                                         input logic [data_w-1:0] wdata);
      mem_req_t r;
      r.addr      = addr[addr_w-1:0];
      r.write     = write;
      r.size      = size;
      r.is_signed = is_signed;
      r.wdata     = wdata;
      return r;
   endfunction

   // one request per call, driven just after the edge
   task automatic send(input mem_req_t r);
      @(posedge clk);
      #1;
      req_valid = 1'b1;
      req       = r;
   endtask

   task automatic idle();
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      req       = '0;
   endtask

   task automatic fill_words();
      for (int w = 0; w < mem_words; w++)
         send(make_req(w * 4, 1'b1, size_word, 1'b0, $random(seed)));
      for (int w = 0; w < mem_words; w++)
         send(make_req(w * 4, 1'b0, size_word, 1'b0, '0));
   endtask

   // narrow stores, whole-word readback after each
   task automatic lane_stores();
      int base;
      for (int w = 0; w < 4; w++) begin
         base = (64 + w) * 4;
         for (int b = 0; b < 4; b++) begin
            send(make_req(base + b, 1'b1, size_byte, 1'b0, $random(seed)));
            send(make_req(base, 1'b0, size_word, 1'b0, '0));
         end
         for (int h = 0; h < 2; h++) begin
            send(make_req(base + 2 * h, 1'b1, size_half, 1'b0, $random(seed)));
            send(make_req(base, 1'b0, size_word, 1'b0, '0));
         end
      end
   endtask

   // patterns mix set and clear top bits in every lane
   task automatic extend_loads();
      logic [1:0][data_w-1:0] pattern;
      int                     base;
      pattern[0] = 32'h80ff7f01;
      pattern[1] = 32'h017f80fe;
      for (int p = 0; p < 2; p++) begin
         base = (128 + p) * 4;
         send(make_req(base, 1'b1, size_word, 1'b0, pattern[p]));
         for (int b = 0; b < 4; b++) begin
            for (int s = 0; s < 2; s++)
               send(make_req(base + b, 1'b0, size_byte, s[0], '0));
         end
         for (int h = 0; h < 2; h++) begin
            for (int s = 0; s < 2; s++)
               send(make_req(base + 2 * h, 1'b0, size_half, s[0], '0));
         end
      end
   endtask

   task automatic misaligned();
      int base;
      base = 200 * 4;
      for (int o = 1; o < 4; o++) begin
         send(make_req(base + o, 1'b1, size_word, 1'b0, $random(seed)));
         send(make_req(base + o, 1'b0, size_word, 1'b0, '0));
      end
      for (int o = 1; o < 4; o += 2) begin
         send(make_req(base + o, 1'b1, size_half, 1'b0, $random(seed)));
         send(make_req(base + o, 1'b0, size_half, 1'b1, '0));
      end
      send(make_req(base, 1'b0, size_word, 1'b0, '0));  // fill value still there
   endtask

   // mixed stream, loads often chase the previous store
   task automatic random_stream();
      mem_req_t r;
      mem_req_t prev;
      prev = '0;
      for (int i = 0; i < n_random; i++) begin
         r.addr      = $random(seed);
         r.write     = $random(seed);
         r.is_signed = $random(seed);
         r.wdata     = $random(seed);
         case ($unsigned($random(seed)) % 3)
            0:       r.size = size_byte;
            1:       r.size = size_half;
            default: r.size = size_word;
         endcase
         if (prev.write && ($random(seed) & 3) == 0) begin
            r.addr  = prev.addr;                // same word, next cycle
            r.write = 1'b0;
         end
         send(r);
         prev = r;
      end
   endtask

   initial begin
      reset       = 1'b1;
      req_valid   = 1'b0;
      req         = '0;
      end_of_test = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (3) idle();                        // quiet window after reset
      fill_words();
      idle();
      lane_stores();
      idle();
      extend_loads();
      idle();
      misaligned();
      idle();
      random_stream();
      idle();
      repeat (2) @(posedge clk);                // last response lands two edges on
      #1;
      end_of_test = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      $display("error counts, value %0d, protocol %0d", value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/scratch_mem_top.sv
`default_nettype none

module scratch_mem_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,  // one-cycle request strobe
   input  scratch_pkg::mem_req_t req,
   output logic                  rsp_valid,  // pulse after edge N+1
   output scratch_pkg::mem_rsp_t rsp
);
   import scratch_pkg::*;

   // decode to memory
   logic                   ce;
   logic                   we;
   logic [word_addr_w-1:0] word_addr;
   logic [sel_w-1:0]       sel;
   logic [data_w-1:0]      wdata;

   // memory and tag to align
   logic [data_w-1:0]      rdata_word;
   logic                   tag_valid;
   load_tag_t              tag;

   sram_access_decode u_decode (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .ce        (ce),
      .we        (we),
      .word_addr (word_addr),
      .sel       (sel),
      .wdata     (wdata),
      .tag_valid (tag_valid),
      .tag       (tag)
   );

   sram_sp_plain u_mem (
      .clk        (clk),
      .ce         (ce),
      .we         (we),
      .word_addr  (word_addr),
      .sel        (sel),
      .wdata      (wdata),
      .rdata_word (rdata_word)
   );

   sram_load_align u_align (
      .clk        (clk),
      .reset      (reset),
      .rdata_word (rdata_word),
      .tag_valid  (tag_valid),
      .tag        (tag),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

`default_nettype wire

// File: verilog/scratch_pkg.sv
`default_nettype none

package scratch_pkg;

   // scratchpad geometry, 1 KiB of 32-bit words
   localparam int addr_w      = 10;             // byte address
   localparam int data_w      = 32;             // word width
   localparam int byte_w      = 8;
   localparam int sel_w       = data_w / byte_w; // byte lanes per word
   localparam int lsb_w       = $clog2(sel_w);   // byte offset bits inside a word
   localparam int mem_words   = 256;
   localparam int word_addr_w = addr_w - lsb_w;  // 8 bits for 256 words

   // access size as issued by the requester
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } access_size_e;

   // one bus-side request, valid alongside req_valid
   typedef struct packed {
      logic [addr_w-1:0] addr;      // byte address
      logic              write;     // 1 = store
      access_size_e      size;
      logic              is_signed; // loads only
      logic [data_w-1:0] wdata;     // low bits hold the value for byte/half
   } mem_req_t;

   // response, one pulse per request
   typedef struct packed {
      logic [data_w-1:0] rdata;     // extended load data, zero on store or error
      logic              err;       // misaligned access
      logic              write;     // echo of request kind
   } mem_rsp_t;

   // a memory word seen as byte lanes or as halfword lanes
   // decode side uses it to replicate store data
   // align side uses it to pick the addressed load lane
   typedef union packed {
      logic [sel_w-1:0][byte_w-1:0]     bytes;
      logic [sel_w/2-1:0][2*byte_w-1:0] halves;
   } lane_word_u;

   // what the output side needs to know about the access in flight
   // rides one cycle next to the memory read
   typedef struct packed {
      logic [lsb_w-1:0] lsb;        // byte offset inside the word
      access_size_e     size;
      logic             is_signed;
      logic             write;
      logic             err;        // misaligned, memory untouched
   } load_tag_t;                    // 2+2+1+1+1 = 7 bits

endpackage

`default_nettype wire

// File: verilog/sram_access_decode.sv
`default_nettype none

module sram_access_decode (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req_valid,   // one-cycle strobe
   input  scratch_pkg::mem_req_t               req,
   output logic                                ce,          // memory strobes
   output logic                                we,
   output logic [scratch_pkg::word_addr_w-1:0] word_addr,
   output logic [scratch_pkg::sel_w-1:0]       sel,
   output logic [scratch_pkg::data_w-1:0]      wdata,
   output logic                                tag_valid,   // access in memory stage
   output scratch_pkg::load_tag_t              tag
);
   import scratch_pkg::*;

   logic [lsb_w-1:0] lsb;       // byte offset of the request
   logic             aligned;
   lane_word_u       wlanes;    // store data spread over lanes
   load_tag_t        tag_next;

   assign lsb = req.addr[lsb_w-1:0];

   // alignment against access size
   always_comb begin
      case (req.size)
         size_byte: aligned = 1'b1;              // any offset
         size_half: aligned = ~lsb[0];           // even offsets only
         size_word: aligned = (lsb == '0);
         default:   aligned = 1'b0;              // reserved size, flagged as error
      endcase
   end

   // byte selects for the addressed lanes
   always_comb begin
      sel = '0;
      case (req.size)
         size_byte: sel[lsb] = 1'b1;
         size_half: begin
            if (lsb[1])
               sel = 4'b1100;                    // upper half
            else
               sel = 4'b0011;                    // lower half
         end
         size_word: sel = '1;
         default:   sel = '0;
      endcase
   end

   // replicate store value across the lanes
   // memory picks the right copy through sel
   always_comb begin
      wlanes = req.wdata;                        // word store as is
      case (req.size)
         size_byte: begin
            for (int i = 0; i < sel_w; i++)
               wlanes.bytes[i] = req.wdata[byte_w-1:0];
         end
         size_half: begin
            for (int i = 0; i < sel_w / 2; i++)
               wlanes.halves[i] = req.wdata[2*byte_w-1:0];
         end
         default: ;
      endcase
   end

   // misaligned requests never reach the array
   assign ce        = req_valid & aligned;
   assign we        = ce & req.write;
   assign word_addr = req.addr[addr_w-1:lsb_w];
   assign wdata     = wlanes;

   always_comb begin
      tag_next.lsb       = lsb;
      tag_next.size      = req.size;
      tag_next.is_signed = req.is_signed;
      tag_next.write     = req.write;
      tag_next.err       = ~aligned;
   end

   // tag follows the read word by one edge
   always_ff @(posedge clk) begin
      if (reset) begin
         tag_valid <= 1'b0;
      end else begin
         tag_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         tag <= tag_next;                        // payload only
      end
   end

   // a store strobe always comes with chip enable and some lane
   a_write_strobe: assert property (@(posedge clk) disable iff (reset)
      we |-> ce && (sel != '0));

endmodule

`default_nettype wire

// File: verilog/sram_load_align.sv
`default_nettype none

module sram_load_align (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [scratch_pkg::data_w-1:0] rdata_word,  // from memory read register
   input  logic                           tag_valid,
   input  scratch_pkg::load_tag_t         tag,
   output logic                           rsp_valid,   // one pulse per request
   output scratch_pkg::mem_rsp_t          rsp
);
   import scratch_pkg::*;

   lane_word_u          rlanes;      // read word seen as lanes
   logic [byte_w-1:0]   pick_b;      // addressed byte
   logic [2*byte_w-1:0] pick_h;      // addressed halfword
   logic [data_w-1:0]   load_data;   // extended load value
   mem_rsp_t            rsp_next;

   assign rlanes = rdata_word;
   assign pick_b = rlanes.bytes[tag.lsb];
   assign pick_h = rlanes.halves[tag.lsb[1]];  // lsb[0] is zero when aligned

   // sign or zero extension
   always_comb begin
      case (tag.size)
         size_byte: begin
            if (tag.is_signed)
               load_data = {{(data_w-byte_w){pick_b[byte_w-1]}}, pick_b};
            else
               load_data = {{(data_w-byte_w){1'b0}}, pick_b};
         end
         size_half: begin
            if (tag.is_signed)
               load_data = {{(data_w-2*byte_w){pick_h[2*byte_w-1]}}, pick_h};
            else
               load_data = {{(data_w-2*byte_w){1'b0}}, pick_h};
         end
         default: load_data = rdata_word;        // full word
      endcase
   end

   // stores and errors return zero data
   always_comb begin
      rsp_next.err   = tag.err;
      rsp_next.write = tag.write;
      if (tag.write || tag.err)
         rsp_next.rdata = '0;
      else
         rsp_next.rdata = load_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= tag_valid;                 // one pulse per tag
      end
   end

   always_ff @(posedge clk) begin
      if (tag_valid) begin
         rsp <= rsp_next;                        // held between pulses
      end
   end

   // back-to-back responses only when the tag stage was busy two cycles in a row
   a_rsp_pulse: assert property (@(posedge clk) disable iff (reset)
      rsp_valid && $past(rsp_valid) |-> $past(tag_valid) && $past(tag_valid, 2));

endmodule

`default_nettype wire

// File: verilog/sram_sp_plain.sv
`default_nettype none

module sram_sp_plain (
   input  logic                                clk,
   input  logic                                ce,          // chip enable
   input  logic                                we,          // write enable
   input  logic [scratch_pkg::word_addr_w-1:0] word_addr,
   input  logic [scratch_pkg::sel_w-1:0]       sel,         // byte lanes to write
   input  logic [scratch_pkg::data_w-1:0]      wdata,
   output logic [scratch_pkg::data_w-1:0]      rdata_word   // registered read
);
   import scratch_pkg::*;

   // plain register array, contents undefined until written
   logic [data_w-1:0] mem [mem_words];

   // write selected lanes on the sampling edge
   always_ff @(posedge clk) begin
      if (ce && we) begin
         for (int i = 0; i < sel_w; i++) begin
            if (sel[i]) begin
               mem[word_addr][i*byte_w +: byte_w] <= wdata[i*byte_w +: byte_w];
            end
         end
      end
   end

   // read register
   // same-edge write is not bypassed, old word comes out
   always_ff @(posedge clk) begin
      if (ce) begin
         rdata_word <= mem[word_addr];
      end
   end

   // address must be known whenever the array is touched
   a_addr_known: assert property (@(posedge clk)
      ce |-> !$isunknown(word_addr));

   // lane selects on a store must be known too
   a_sel_known: assert property (@(posedge clk)
      ce && we |-> !$isunknown(sel));

endmodule

`default_nettype wire
